/* logic/memory_pkg.sv */
// memory side shared definitions
// widths, cache geometry, bus command encoding and the request and
// reply bundles used by both caches, the arbiter and the memory port
package memory_pkg;

    ////////////////////
    // geometry
    ////////////////////

    // byte address
    localparam int addr_width  = 32;
    // one line holds one double word
    localparam int line_bytes  = 8;
    localparam int offset_bits = $clog2(line_bytes);
    localparam int cache_lines = 32;
    localparam int index_bits  = $clog2(cache_lines);
    // what is left of the address after index and offset
    localparam int tag_bits    = addr_width - index_bits - offset_bits;

    ////////////////////
    // types
    ////////////////////

    typedef logic [addr_width-1:0]     addr_t;
    typedef logic [line_bytes*8-1:0]   line_t;
    // zero means no transaction
    typedef logic [3:0]                mem_tag_t;
    typedef logic [tag_bits-1:0]       cache_tag_t;

    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_command_t;

    // request towards memory, 98 bits
    typedef struct packed {
        bus_command_t command;
        addr_t        addr;
        line_t        data;
    } mem_request_t;

    // load data broadcast by memory, 68 bits
    typedef struct packed {
        mem_tag_t tag;
        line_t    data;
    } mem_reply_t;

    // fsm states, one set per cache
    typedef enum logic [1:0] {
        ic_idle,
        ic_request,
        ic_wait_data
    } icache_state_t;

    typedef enum logic [2:0] {
        dc_idle,
        dc_lookup,
        dc_miss_request,
        dc_miss_wait,
        dc_store_request
    } dcache_state_t;

    ////////////////////
    // address fields
    ////////////////////

    function automatic logic [index_bits-1:0] get_index(addr_t addr);
        return addr[offset_bits +: index_bits];
    endfunction

    function automatic cache_tag_t get_tag(addr_t addr);
        return addr[addr_width-1 -: tag_bits];
    endfunction

    // offset bits cleared
    function automatic addr_t line_base(addr_t addr);
        return {addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
    endfunction

endpackage

/* logic/instruction_cache.sv */
// instruction cache
// direct-mapped, read-only, one line per double word
// hits answer in the same cycle as the fetch address
// misses load the line over the shared bus and fill on the tagged reply
module instruction_cache
    import memory_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  addr_t        fetch_addr,
    output line_t        fetch_data,
    output logic         fetch_valid,
    output mem_request_t icache_request,
    input  mem_tag_t     icache_response,
    input  mem_reply_t   mem_reply
);

    // storage arrays
    line_t                  data_array [cache_lines];
    cache_tag_t             tag_array  [cache_lines];
    logic [cache_lines-1:0] valid_bits;

    icache_state_t          state;
    // address of the line being fetched
    addr_t                  miss_addr;
    // tag handed out by memory for the outstanding load
    mem_tag_t               pending_tag;

    logic [index_bits-1:0]  fetch_index;
    logic [index_bits-1:0]  fill_index;
    logic                   hit;
    logic                   fill_done;

    ////////////////////
    // lookup
    ////////////////////

    assign fetch_index = get_index(fetch_addr);
    assign hit         = valid_bits[fetch_index] &&
                         (tag_array[fetch_index] == get_tag(fetch_addr));
    assign fetch_data  = data_array[fetch_index];
    assign fetch_valid = hit;

    // fill side follows the captured miss address
    assign fill_index  = get_index(miss_addr);
    assign fill_done   = (state == ic_wait_data) && (mem_reply.tag == pending_tag);

    ////////////////////
    // bus request
    ////////////////////

    always_comb begin
        icache_request         = '0;
        icache_request.command = bus_none;
        // held every cycle until memory accepts
        if (state == ic_request) begin
            icache_request.command = bus_load;
            icache_request.addr    = line_base(miss_addr);
        end
    end

    ////////////////////
    // control fsm
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= ic_idle;
            valid_bits  <= '0;
            pending_tag <= '0;
        end else begin
            case (state)
                ic_idle: begin
                    // miss seen, request from next cycle
                    if (!hit) begin
                        state <= ic_request;
                    end
                end
                ic_request: begin
                    // refused requests just stay here
                    if (icache_response != '0) begin
                        pending_tag <= icache_response;
                        state       <= ic_wait_data;
                    end
                end
                ic_wait_data: begin
                    if (fill_done) begin
                        valid_bits[fill_index] <= 1'b1;
                        state                  <= ic_idle;
                    end
                end
                default: begin
                    state <= ic_idle;
                end
            endcase
        end
    end

    // miss address and line payload
    always_ff @(posedge clock) begin
        if ((state == ic_idle) && !hit) begin
            miss_addr <= fetch_addr;
        end
        if (fill_done) begin
            data_array[fill_index] <= mem_reply.data;
            tag_array[fill_index]  <= get_tag(miss_addr);
        end
    end

endmodule

/* logic/data_cache.sv */
// data cache
// direct-mapped, write-through, no write allocate
// one double-word load or store at a time taken as a strobe while idle
// load hits answer one cycle after capture
// load misses fill from memory
// every store goes to memory and also updates a hit line
module data_cache
    import memory_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  bus_command_t data_command,
    input  addr_t        data_addr,
    input  line_t        data_wdata,
    output line_t        load_data,
    output logic         load_valid,
    output logic         data_busy,
    output mem_request_t dcache_request,
    input  mem_tag_t     dcache_response,
    input  mem_reply_t   mem_reply
);

    // storage arrays
    line_t                  data_array [cache_lines];
    cache_tag_t             tag_array  [cache_lines];
    logic [cache_lines-1:0] valid_bits;

    dcache_state_t          state;
    // operation in progress held in bus request form
    mem_request_t           current;
    mem_tag_t               pending_tag;

    logic                   capture;
    logic                   capture_store;
    logic [index_bits-1:0]  in_index;
    logic                   in_hit;
    logic [index_bits-1:0]  cur_index;
    logic                   cur_hit;
    logic                   reply_match;

    ////////////////////
    // decode
    ////////////////////

    assign data_busy     = (state != dc_idle);
    // commands while busy are dropped
    assign capture       = (state == dc_idle) && (data_command != bus_none);
    assign capture_store = capture && (data_command == bus_store);

    // incoming address hit check for the store update at capture
    assign in_index = get_index(data_addr);
    assign in_hit   = valid_bits[in_index] && (tag_array[in_index] == get_tag(data_addr));

    // captured address hit check for loads
    assign cur_index = get_index(current.addr);
    assign cur_hit   = valid_bits[cur_index] &&
                       (tag_array[cur_index] == get_tag(current.addr));

    assign reply_match = (state == dc_miss_wait) && (mem_reply.tag == pending_tag);

    ////////////////////
    // bus request
    ////////////////////

    always_comb begin
        dcache_request         = '0;
        dcache_request.command = bus_none;
        case (state)
            dc_miss_request: begin
                dcache_request.command = current.command;
                dcache_request.addr    = line_base(current.addr);
            end
            dc_store_request: begin
                dcache_request.command = current.command;
                dcache_request.addr    = line_base(current.addr);
                dcache_request.data    = current.data;
            end
            default: begin
                dcache_request.command = bus_none;
            end
        endcase
    end

    ////////////////////
    // control fsm
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= dc_idle;
            valid_bits  <= '0;
            pending_tag <= '0;
            load_valid  <= 1'b0;
        end else begin
            // single-cycle pulse
            load_valid <= 1'b0;
            case (state)
                dc_idle: begin
                    if (capture_store) begin
                        state <= dc_store_request;
                    end else if (capture) begin
                        state <= dc_lookup;
                    end
                end
                dc_lookup: begin
                    if (cur_hit) begin
                        load_valid <= 1'b1;
                        state      <= dc_idle;
                    end else begin
                        state <= dc_miss_request;
                    end
                end
                dc_miss_request: begin
                    if (dcache_response != '0) begin
                        pending_tag <= dcache_response;
                        state       <= dc_miss_wait;
                    end
                end
                dc_miss_wait: begin
                    // fill and answer together
                    if (reply_match) begin
                        valid_bits[cur_index] <= 1'b1;
                        load_valid            <= 1'b1;
                        state                 <= dc_idle;
                    end
                end
                dc_store_request: begin
                    // done once memory takes it
                    if (dcache_response != '0) begin
                        state <= dc_idle;
                    end
                end
                default: begin
                    state <= dc_idle;
                end
            endcase
        end
    end

    ////////////////////
    // payload
    ////////////////////

    always_ff @(posedge clock) begin
        if (capture) begin
            current.command <= data_command;
            current.addr    <= data_addr;
            current.data    <= data_wdata;
        end
        // store hit updates the line right away
        if (capture_store && in_hit) begin
            data_array[in_index] <= data_wdata;
        end
        if ((state == dc_lookup) && cur_hit) begin
            load_data <= data_array[cur_index];
        end
        if (reply_match) begin
            data_array[cur_index] <= mem_reply.data;
            tag_array[cur_index]  <= get_tag(current.addr);
            load_data             <= mem_reply.data;
        end
    end

endmodule

/* logic/memory_arbiter.sv */
// memory bus arbiter
// picks one of the two cache requests for the shared memory port
// a lone requester wins at once, a contested cycle goes round-robin
// the same-cycle accept tag only reaches the granted cache
module memory_arbiter
    import memory_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  mem_request_t icache_request,
    input  mem_request_t dcache_request,
    output mem_request_t mem_request,
    input  mem_tag_t     mem_response,
    output mem_tag_t     icache_response,
    output mem_tag_t     dcache_response
);

    logic icache_wants;
    logic dcache_wants;
    logic grant_icache;
    logic grant_dcache;
    // high when the icache won the last contested cycle
    logic last_grant;

    ////////////////////
    // grant
    ////////////////////

    assign icache_wants = (icache_request.command != bus_none);
    assign dcache_wants = (dcache_request.command != bus_none);

    // contested cycle goes to whoever lost last time
    assign grant_icache = icache_wants && (!dcache_wants || !last_grant);
    assign grant_dcache = dcache_wants && !grant_icache;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // dcache goes first after reset
            last_grant <= 1'b1;
        end else if (icache_wants && dcache_wants) begin
            // refused or not, the winner is recorded
            last_grant <= grant_icache;
        end
    end

    ////////////////////
    // bus mux
    ////////////////////

    always_comb begin
        mem_request         = '0;
        mem_request.command = bus_none;
        if (grant_icache) begin
            mem_request = icache_request;
        end else if (grant_dcache) begin
            mem_request = dcache_request;
        end
    end

    // accept tag steering
    // the loser sees zero and keeps its request up
    assign icache_response = grant_icache ? mem_response : '0;
    assign dcache_response = grant_dcache ? mem_response : '0;

endmodule

/* logic/memory_system.sv */
// memory system top level
// instruction cache and data cache sharing one tagged memory port
// through the round-robin arbiter, no added cycles
module memory_system
    import memory_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  addr_t        fetch_addr,
    output line_t        fetch_data,
    output logic         fetch_valid,
    input  bus_command_t data_command,
    input  addr_t        data_addr,
    input  line_t        data_wdata,
    output line_t        load_data,
    output logic         load_valid,
    output logic         data_busy,
    output mem_request_t mem_request,
    input  mem_tag_t     mem_response,
    input  mem_reply_t   mem_reply
);

    // cache side of the arbiter
    mem_request_t icache_request;
    mem_request_t dcache_request;
    mem_tag_t     icache_response;
    mem_tag_t     dcache_response;

    instruction_cache i_instruction_cache (
        .clock           (clock),
        .reset           (reset),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data),
        .fetch_valid     (fetch_valid),
        .icache_request  (icache_request),
        .icache_response (icache_response),
        .mem_reply       (mem_reply)
    );

    data_cache i_data_cache (
        .clock           (clock),
        .reset           (reset),
        .data_command    (data_command),
        .data_addr       (data_addr),
        .data_wdata      (data_wdata),
        .load_data       (load_data),
        .load_valid      (load_valid),
        .data_busy       (data_busy),
        .dcache_request  (dcache_request),
        .dcache_response (dcache_response),
        .mem_reply       (mem_reply)
    );

    // reply broadcast goes straight to both caches
    memory_arbiter i_memory_arbiter (
        .clock           (clock),
        .reset           (reset),
        .icache_request  (icache_request),
        .dcache_request  (dcache_request),
        .mem_request     (mem_request),
        .mem_response    (mem_response),
        .icache_response (icache_response),
        .dcache_response (dcache_response)
    );

endmodule

/* testbench/memory_system_assertions.sv */
// arbiter bus checks
// accept tags reach at most one cache, and only a requesting one
// the bus stays idle when neither cache requests
module memory_system_assertions
    import memory_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input mem_request_t icache_request,
    input mem_request_t dcache_request,
    input mem_request_t mem_request,
    input mem_tag_t     icache_response,
    input mem_tag_t     dcache_response
);

    never_both_accepted: assert property (
        @(posedge clock) disable iff (reset)
        !((icache_response != '0) && (dcache_response != '0))
    ) else $error("both caches received an accept tag in the same cycle");

    // tag only to a cache that asked
    icache_accept_requested: assert property (
        @(posedge clock) disable iff (reset)
        (icache_response != '0) |-> (icache_request.command != bus_none)
    ) else $error("instruction cache got an accept tag without a request");

    dcache_accept_requested: assert property (
        @(posedge clock) disable iff (reset)
        (dcache_response != '0) |-> (dcache_request.command != bus_none)
    ) else $error("data cache got an accept tag without a request");

    idle_bus_when_no_request: assert property (
        @(posedge clock) disable iff (reset)
        ((icache_request.command == bus_none) && (dcache_request.command == bus_none))
            |-> (mem_request.command == bus_none)
    ) else $error("memory bus active with no cache requesting");

endmodule

bind memory_arbiter memory_system_assertions i_memory_system_assertions (
    .clock           (clock),
    .reset           (reset),
    .icache_request  (icache_request),
    .dcache_request  (dcache_request),
    .mem_request     (mem_request),
    .icache_response (icache_response),
    .dcache_response (dcache_response)
);

/* testbench/memory_system_tb.sv */
// memory system testbench
// random fetch stream and random double-word load/store stream run together
// memory model refuses some requests, hands out rotating tags and replies
// after a random latency
// checks compare against a reference copy of memory
module memory_system_tb
    import memory_pkg::*;
();

    localparam int clock_period    = 4;
    localparam int fetch_count     = 200;
    localparam int data_count      = 200;
    localparam int max_latency     = 6;
    localparam int watchdog_cycles = (fetch_count + data_count) * max_latency * 4;
    // modelled memory holds the fetch region in words 0..511 and data lines above
    localparam int word_bits       = 10;
    localparam int mem_words       = 1 << word_bits;
    localparam int data_base_word  = 512;
    // spacing gives pairs of data lines sharing one cache index
    localparam int data_stride     = 20;
    localparam addr_t region_end   = addr_t'(mem_words * line_bytes);

    logic         clock;
    logic         reset;
    addr_t        fetch_addr;
    line_t        fetch_data;
    logic         fetch_valid;
    bus_command_t data_command;
    addr_t        data_addr;
    line_t        data_wdata;
    line_t        load_data;
    logic         load_valid;
    logic         data_busy;
    mem_request_t mem_request;
    mem_tag_t     mem_response;
    mem_reply_t   mem_reply;

    int           seed;
    int           cycle_count;
    mem_tag_t     next_tag;
    // external memory and the expected contents
    line_t        memory_words   [mem_words];
    line_t        expected_words [mem_words];
    // queued load replies
    mem_tag_t     reply_tag_q  [$];
    line_t        reply_data_q [$];
    int           reply_due_q  [$];

    logic         fetch_active;
    int           fetch_done;
    logic         data_active;
    logic         data_is_load;
    logic         data_predict_hit;
    int           data_age;
    int           data_done;
    line_t        data_expected;
    // line last filled at each index by a load
    int           resident_line [cache_lines];

    memory_system i_memory_system (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid),
        .data_command (data_command),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .data_busy    (data_busy),
        .mem_request  (mem_request),
        .mem_response (mem_response),
        .mem_reply    (mem_reply)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    ////////////////////
    // check helpers
    ////////////////////

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string test_name, input line_t expected, input line_t actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", test_name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string test_name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Error: %s expected %0d actual %0d", test_name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_condition(input logic condition, input string what);
        assert (condition) else begin
            $display("%s", what);
            stop_on_failure();
        end
    endtask

    // preload value built from the full byte address
    function automatic line_t initial_word(int word);
        addr_t base;
        base = addr_t'(word * line_bytes);
        return {base ^ 32'h5a5a_c3c3, (base * 32'h9e37_79b9) ^ 32'h0f1e_2d3c};
    endfunction

    function automatic int word_of(addr_t addr);
        return int'(addr[offset_bits +: word_bits]);
    endfunction

    ////////////////////
    // memory model
    ////////////////////

    // one reply per cycle at most with the oldest due entry first
    task automatic send_reply();
        int pick;
        int i;
        pick = -1;
        for (i = 0; i < reply_due_q.size(); i++) begin
            if ((pick < 0) && (reply_due_q[i] <= cycle_count)) begin
                pick = i;
            end
        end
        mem_reply = '0;
        if (pick >= 0) begin
            mem_reply.tag  = reply_tag_q[pick];
            mem_reply.data = reply_data_q[pick];
            reply_tag_q.delete(pick);
            reply_data_q.delete(pick);
            reply_due_q.delete(pick);
        end
    endtask

    task automatic drive_memory();
        logic [31:0] rnd;
        int          word;
        int          latency;
        cycle_count++;
        send_reply();
        mem_response = '0;
        if (mem_request.command != bus_none) begin
            check_condition(mem_request.addr < region_end,
                            "memory request outside the modelled address range");
            rnd = $random(seed);
            // roughly one in four refused
            if (rnd[1:0] != 2'b00) begin
                word         = word_of(mem_request.addr);
                mem_response = next_tag;
                if (mem_request.command == bus_store) begin
                    memory_words[word] = mem_request.data;
                end else begin
                    latency = 2 + (int'(rnd[7:3]) % 5);
                    reply_tag_q.push_back(next_tag);
                    reply_data_q.push_back(memory_words[word]);
                    reply_due_q.push_back(cycle_count + latency);
                end
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
        end
    endtask

    ////////////////////
    // fetch stream
    ////////////////////

    task automatic drive_fetch();
        logic [31:0] rnd;
        if (fetch_active && fetch_valid) begin
            check_value("fetch", initial_word(word_of(fetch_addr)), fetch_data);
            fetch_done++;
            fetch_active = 1'b0;
        end
        if (!fetch_active && (fetch_done < fetch_count)) begin
            rnd          = $random(seed);
            fetch_addr   = {20'h0, rnd[11:0]};
            fetch_active = 1'b1;
        end
    endtask

    ////////////////////
    // data stream
    ////////////////////

    task automatic issue_data_op();
        logic [31:0] rnd;
        logic [31:0] high_half;
        logic [31:0] low_half;
        int          word;
        int          slot;
        rnd       = $random(seed);
        word      = data_base_word + int'(rnd[3:0]) * data_stride;
        slot      = word % cache_lines;
        data_addr = addr_t'(word * line_bytes);
        data_age  = 0;
        data_active = 1'b1;
        if (rnd[4]) begin
            high_half            = $random(seed);
            low_half             = $random(seed);
            data_wdata           = {high_half, low_half};
            expected_words[word] = data_wdata;
            data_is_load         = 1'b0;
            data_command         = bus_store;
        end else begin
            data_expected       = expected_words[word];
            // stores never allocate so only loads change what is resident
            data_predict_hit    = (resident_line[slot] == word);
            resident_line[slot] = word;
            data_is_load        = 1'b1;
            data_command        = bus_load;
        end
    endtask

    task automatic drive_data();
        // strobe lasts one cycle
        data_command = bus_none;
        if (data_active) begin
            data_age++;
            if (data_age == 1) begin
                check_condition(data_busy, "data_busy did not rise after the request was taken");
            end
            if (!data_is_load) begin
                check_condition(!load_valid, "load_valid pulsed during a store");
            end
            if (data_is_load && load_valid) begin
                check_value("load", data_expected, load_data);
                check_condition(!data_busy, "data_busy still high with load_valid");
                // capture edge plus exactly one cycle
                if (data_predict_hit) begin
                    check_count("load hit latency", 1, data_age - 1);
                end
                data_active = 1'b0;
                data_done++;
            end else if (!data_is_load && (data_age > 1) && !data_busy) begin
                data_active = 1'b0;
                data_done++;
            end
        end else begin
            check_condition(!load_valid, "load_valid pulsed with no load outstanding");
        end
        if (!data_active && (data_done < data_count)) begin
            issue_data_op();
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        seed             = 42;
        cycle_count      = 0;
        next_tag         = 4'd1;
        reset            = 1'b1;
        fetch_addr       = '0;
        data_command     = bus_none;
        data_addr        = '0;
        data_wdata       = '0;
        mem_response     = '0;
        mem_reply        = '0;
        fetch_active     = 1'b0;
        fetch_done       = 0;
        data_active      = 1'b0;
        data_is_load     = 1'b0;
        data_predict_hit = 1'b0;
        data_age         = 0;
        data_done        = 0;
        data_expected    = '0;
        for (int w = 0; w < mem_words; w++) begin
            memory_words[w]   = initial_word(w);
            expected_words[w] = initial_word(w);
        end
        for (int s = 0; s < cache_lines; s++) begin
            resident_line[s] = -1;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        // idle outputs while still in reset
        check_condition(!fetch_valid, "fetch_valid high during reset");
        check_condition(!load_valid, "load_valid high during reset");
        check_condition(!data_busy, "data_busy high during reset");
        check_condition(mem_request.command == bus_none, "memory request active during reset");
        reset = 1'b0;
        while ((fetch_done < fetch_count) || (data_done < data_count)) begin
            @(negedge clock);
            drive_memory();
            drive_fetch();
            drive_data();
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // bound on the whole run
    initial begin
        #(watchdog_cycles * clock_period);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout, fetch and data operations did not all complete");
    end

endmodule

/* files.f */
logic/memory_pkg.sv
logic/instruction_cache.sv
logic/data_cache.sv
logic/memory_arbiter.sv
logic/memory_system.sv
testbench/memory_system_assertions.sv
testbench/memory_system_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module memory_system_tb -f files.f -o memory_system_sim
	./obj_dir/memory_system_sim | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
